// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       := zx_mem_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/zx_mem_assert.sv
// Concurrent checks on the shared memory arbiter
// Grant exclusivity, loader ownership and the grant to read-valid return

module zx_mem_assert (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   load_active,
	input zx_bus_pkg::mem_grant_t gnt,
	input logic                   cpu_gnt,
	input logic                   tape_gnt,
	input logic                   cpu_rvalid,
	input logic                   tape_rvalid
);
	timeunit 1ns;
	timeprecision 100ps;
	import zx_bus_pkg::*;

	int fail_count = 0;

	// One owner per cycle
	one_grant_a: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({gnt == grant_loader, tape_gnt, cpu_gnt}))
	else begin
		fail_count++;
		$error("More than one client granted the memory");
	end

	// An active loader keeps the other clients out
	loader_only_a: assert property (@(posedge clk_sys) disable iff (reset)
		load_active |-> !cpu_gnt && !tape_gnt)
	else begin
		fail_count++;
		$error("CPU or tape granted while the loader is active");
	end

	// Each grant returns exactly one rvalid, to its own client
	cpu_return_a: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_gnt |=> cpu_rvalid && !cpu_gnt)
	else begin
		fail_count++;
		$error("CPU grant not followed by exactly one cpu_rvalid");
	end

	tape_return_a: assert property (@(posedge clk_sys) disable iff (reset)
		tape_gnt |=> tape_rvalid && !tape_gnt)
	else begin
		fail_count++;
		$error("Tape grant not followed by exactly one tape_rvalid");
	end

endmodule

bind mem_arbiter zx_mem_assert arbiter_checks_i (
	.clk_sys(clk_sys), .reset(reset), .load_active(load_active), .gnt(gnt),
	.cpu_gnt(cpu_gnt), .tape_gnt(tape_gnt), .cpu_rvalid(cpu_rvalid),
	.tape_rvalid(tape_rvalid)
);

// File: dv/zx_mem_tb.sv
// Testbench for the 128K memory subsystem
// Seeded random stimulus, reference model of memory and ports, watchdog

module zx_mem_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import zx_mem_pkg::*;
	import zx_bus_pkg::*;

	localparam int CLK_PERIOD_NS = 4;
	localparam int TAPE_PTR_W    = 16;
	localparam int PAGE_BYTES    = 1 << PAGE_OFS_W;
	localparam int CPU_TIMEOUT   = 64;
	localparam int TAPE_TIMEOUT  = 64;
	localparam int LOAD_HOLD     = 8;

	// Operation counts per test
	localparam int FILL_BYTES  = 32'h3_8000;
	localparam int N_ROM0      = 32;
	localparam int N_MIXED     = 400;
	localparam int N_ROM       = 24;
	localparam int N_LOCKED    = 12;
	localparam int N_BORDER    = 48;
	localparam int N_TAPE      = 300;
	localparam int TOTAL_OPS   = FILL_BYTES + N_ROM0 + N_MIXED + 3 * N_ROM +
		4 * N_LOCKED + N_BORDER + 2 * N_TAPE + 64;
	localparam int OP_CYCLES   = 16;
	localparam int WATCHDOG_NS = TOTAL_OPS * OP_CYCLES * CLK_PERIOD_NS;

	logic                  clk_sys = 1'b0;
	logic                  reset;
	logic                  machine_sel;
	logic [15:0]           cpu_addr;
	logic [7:0]            cpu_wdata;
	logic                  mreq;
	logic                  iorq;
	logic                  rd;
	logic                  wr;
	logic                  load_active;
	logic                  load_wr;
	logic [RAM_ADDR_W-1:0] load_addr;
	logic [7:0]            load_data;
	logic                  tape_next;
	logic                  tape_rewind;
	logic [7:0]            cpu_din;
	logic                  cpu_ready;
	logic [2:0]            border_color;
	logic                  ear_out;
	logic                  mic_out;
	logic [7:0]            tape_byte;
	logic                  tape_byte_valid;

	// Reference model state
	logic [7:0]            model_mem [0:(1 << RAM_ADDR_W) - 1];
	logic [2:0]            m_page;
	logic                  m_rom;
	logic                  m_lock;
	logic                  m_48;
	logic [2:0]            m_border;
	logic                  m_mic;
	logic                  m_ear;
	logic [TAPE_PTR_W-1:0] m_tape_ptr;

	integer seed;
	int     checks;
	int     errors;
	int     last_latency;

	zx_mem_top #(.TAPE_PTR_W(TAPE_PTR_W)) dut_i (.*);

	always #(CLK_PERIOD_NS / 2) clk_sys = ~clk_sys;

	// ==================================================
	// Helpers and model
	task automatic next_cycle();
		@(posedge clk_sys);
		#0.5;
	endtask

	function automatic logic [31:0] next_rand();
		return $random(seed);
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// Physical address for a CPU address under the current paging
	function automatic logic [RAM_ADDR_W-1:0] map_addr(input logic [15:0] a);
		logic [RAM_ADDR_W-1:0] base;
		case (a[15:14])
			2'd0: base = RAM_ADDR_W'(ROM_BASE) +
				((m_rom || m_48) ? RAM_ADDR_W'(PAGE_BYTES) : RAM_ADDR_W'(0));
			2'd1: base = RAM_ADDR_W'(PAGE_SCREEN_LO * PAGE_BYTES);
			2'd2: base = RAM_ADDR_W'(PAGE_MID * PAGE_BYTES);
			default: base = RAM_ADDR_W'(32'(m_page) * PAGE_BYTES);
		endcase
		return base + RAM_ADDR_W'(a[13:0]);
	endfunction

	function automatic void model_io_write(input logic [15:0] a, input logic [7:0] d);
		if (!a[PORT7FFD_A15_BIT] && !a[PORT7FFD_A1_BIT] && !m_48 && !m_lock) begin
			m_page = d[2:0];
			m_rom  = d[4];
			m_lock = d[5];
		end
		if (!a[ULA_A0_BIT]) begin
			m_border = d[2:0];
			m_mic    = d[3];
			m_ear    = d[4];
		end
	endfunction

	task automatic apply_reset(input logic sel48);
		reset       = 1'b1;
		machine_sel = sel48;
		repeat (5) next_cycle();
		reset      = 1'b0;
		m_page     = '0;
		m_rom      = 1'b0;
		m_lock     = 1'b0;
		m_48       = sel48;
		m_border   = '0;
		m_mic      = 1'b0;
		m_ear      = 1'b0;
		m_tape_ptr = '0;
		compare("cpu_ready", 32'(cpu_ready), 32'd0);
		compare("tape_byte_valid", 32'(tape_byte_valid), 32'd0);
		compare("ear_out", 32'(ear_out), 32'd0);
		compare("mic_out", 32'(mic_out), 32'd0);
	endtask

	// ==================================================
	// Bus drivers
	task automatic load_memory();
		int                    i;
		logic [RAM_ADDR_W-1:0] a;
		logic [7:0]            d;
		load_active = 1'b1;
		for (i = 0; i < (1 << RAM_ADDR_W); i++) begin
			a = RAM_ADDR_W'(i);
			// Gap between ROM 1 and the tape region is never read
			if (a < RAM_ADDR_W'(ROM_BASE + 2 * PAGE_BYTES) || a >= RAM_ADDR_W'(TAPE_BASE)) begin
				d            = 8'(next_rand());
				model_mem[a] = d;
				load_addr    = a;
				load_data    = d;
				load_wr      = 1'b1;
				next_cycle();
			end
		end
		load_wr = 1'b0;
	endtask

	task automatic cpu_access(input logic [15:0] addr, input logic write,
		input logic [7:0] data, input logic solo);
		int                    waited;
		logic [RAM_ADDR_W-1:0] pa;
		waited    = 0;
		pa        = map_addr(addr);
		cpu_addr  = addr;
		cpu_wdata = data;
		rd        = ~write;
		wr        = write;
		mreq      = 1'b1;
		do begin
			next_cycle();
			waited++;
		end while (!cpu_ready && waited < CPU_TIMEOUT);
		last_latency = waited;
		if (!cpu_ready) begin
			errors++;
			$display("CPU access to address %h never completed", addr);
		end else begin
			if (solo) compare("cpu_ready latency", 32'(waited), 32'd2);
			if (!write) begin
				compare("cpu_din", 32'(cpu_din), 32'(model_mem[pa]));
			end else if (addr[15:14] != 2'd0) begin
				model_mem[pa] = data;
			end
		end
		mreq = 1'b0;
		rd   = 1'b0;
		wr   = 1'b0;
		next_cycle();
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr  = addr;
		cpu_wdata = data;
		iorq      = 1'b1;
		wr        = 1'b1;
		next_cycle();
		iorq = 1'b0;
		wr   = 1'b0;
		model_io_write(addr, data);
		compare("border_color", 32'(border_color), 32'(m_border));
		compare("mic_out", 32'(mic_out), 32'(m_mic));
		compare("ear_out", 32'(ear_out), 32'(m_ear));
		next_cycle();
	endtask

	task automatic tape_fetch();
		int                    waited;
		logic [RAM_ADDR_W-1:0] pa;
		waited    = 0;
		pa        = RAM_ADDR_W'(TAPE_BASE) + RAM_ADDR_W'(m_tape_ptr);
		tape_next = 1'b1;
		next_cycle();
		tape_next = 1'b0;
		while (!tape_byte_valid && waited < TAPE_TIMEOUT) begin
			next_cycle();
			waited++;
		end
		if (!tape_byte_valid) begin
			errors++;
			$display("Tape byte at pointer %h never arrived", m_tape_ptr);
		end else begin
			compare("tape_byte", 32'(tape_byte), 32'(model_mem[pa]));
			m_tape_ptr++;
		end
	endtask

	task automatic tape_rewind_pulse();
		tape_rewind = 1'b1;
		next_cycle();
		tape_rewind = 1'b0;
		m_tape_ptr  = '0;
	endtask

	// ==================================================
	// Test sequence
	initial begin : main
		int          n;
		logic [31:0] r;
		checks       = 0;
		errors       = 0;
		last_latency = 0;
		seed         = 32'hc8c8_4d89;
		reset        = 1'b1;
		machine_sel  = 1'b0;
		cpu_addr     = '0;
		cpu_wdata    = '0;
		mreq         = 1'b0;
		iorq         = 1'b0;
		rd           = 1'b0;
		wr           = 1'b0;
		load_active  = 1'b0;
		load_wr      = 1'b0;
		load_addr    = '0;
		load_data    = '0;
		tape_next    = 1'b0;
		tape_rewind  = 1'b0;
		apply_reset(1'b0);

		// Loader fill, CPU held off until the loader lets go
		load_memory();
		r = next_rand();
		fork
			cpu_access({2'b00, r[13:0]}, 1'b0, 8'h00, 1'b0);
			begin
				repeat (LOAD_HOLD) next_cycle();
				load_active = 1'b0;
			end
		join
		// Waits out the loader, then the usual two edges
		compare("cpu_ready latency", 32'(last_latency), 32'(LOAD_HOLD + 2));
		for (n = 0; n < N_ROM0; n++) begin
			r = next_rand();
			cpu_access({2'b00, r[13:0]}, 1'b0, 8'h00, 1'b1);
		end

		// Paging with random accesses, then page 5 and page 2 aliasing
		for (n = 0; n < N_MIXED; n++) begin
			r = next_rand();
			if (r[3:0] == 4'd0) io_write(16'h7FFD, r[15:8] & 8'hDF);
			else cpu_access(r[31:16], r[4], r[15:8], 1'b1);
		end
		io_write(16'h7FFD, 8'h05);
		r = next_rand();
		cpu_access({2'b11, r[13:0]}, 1'b1, r[23:16], 1'b1);
		cpu_access({2'b01, r[13:0]}, 1'b0, 8'h00, 1'b1);
		io_write(16'h7FFD, 8'h02);
		cpu_access({2'b10, r[13:0]}, 1'b1, r[31:24], 1'b1);
		cpu_access({2'b11, r[13:0]}, 1'b0, 8'h00, 1'b1);

		// ROM window is read-only, ROM select picks the page
		for (n = 0; n < N_ROM; n++) begin
			r = next_rand();
			io_write(16'h7FFD, {3'b000, r[0], 4'b0000});
			cpu_access({2'b00, r[29:16]}, 1'b1, r[15:8], 1'b1);
			cpu_access({2'b00, r[29:16]}, 1'b0, 8'h00, 1'b1);
		end

		// Lock bit, then a 48K machine
		io_write(16'h7FFD, 8'h23);
		for (n = 0; n < 2 * N_LOCKED; n++) begin
			r = next_rand();
			io_write(16'h7FFD, r[7:0]);
			cpu_access(n[0] ? {2'b00, r[29:16]} : r[31:16], 1'b0, 8'h00, 1'b1);
		end
		apply_reset(1'b1);
		for (n = 0; n < 2 * N_LOCKED; n++) begin
			r = next_rand();
			io_write(16'h7FFD, r[7:0]);
			cpu_access(n[0] ? {2'b00, r[29:16]} : r[31:16], 1'b0, 8'h00, 1'b1);
		end
		apply_reset(1'b0);

		// Border port on even addresses only
		for (n = 0; n < N_BORDER; n++) begin
			r = next_rand();
			io_write(r[15:0], r[23:16]);
		end

		// Tape fetches interleaved with CPU traffic
		for (n = 0; n < N_TAPE; n++) begin
			r = next_rand();
			case (r[1:0])
				2'd0: tape_fetch();
				2'd1: cpu_access(r[31:16], r[2], r[15:8], 1'b1);
				2'd2: begin
					fork
						tape_fetch();
						cpu_access(r[31:16], r[2], r[15:8], 1'b0);
					join
				end
				default: begin
					if (r[4:3] == 2'd0) tape_rewind_pulse();
					else tape_fetch();
				end
			endcase
		end

		$display("Checks: %0d  errors: %0d  assertion failures: %0d", checks, errors,
			dut_i.arb_i.arbiter_checks_i.fail_count);
		if (errors == 0 && dut_i.arb_i.arbiter_checks_i.fail_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Run length bound from the operation counts
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

// File: verilog/cpu_mem_client.sv
// CPU side of the shared memory
// Address mapping, ROM write protection and the wait/ready sequence

module cpu_mem_client (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic [15:0]                       cpu_addr,
	input  logic [7:0]                        cpu_wdata,
	input  logic                              mreq,
	input  logic                              rd,
	input  logic                              wr,
	input  logic [2:0]                        page_ram,
	input  logic                              rom_sel,
	input  logic                              cpu_rvalid,
	input  logic [7:0]                        mem_rdata,
	output logic                              cpu_req,
	output logic                              cpu_we,
	output logic [zx_mem_pkg::RAM_ADDR_W-1:0] cpu_maddr,
	output logic [7:0]                        cpu_mwdata,
	output logic [7:0]                        cpu_din,
	output logic                              cpu_ready
);
	import zx_mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_done
	} state_t;

	state_t                state;
	logic                  access;
	logic                  rom_window;
	logic [RAM_ADDR_W-1:0] page_base;

	assign access     = mreq & (rd | wr);
	assign rom_window = (cpu_addr[15:PAGE_OFS_W] == 2'd0);

	// Window decode, each 16K slot picks a physical page
	always_comb begin
		case (cpu_addr[15:PAGE_OFS_W])
			2'd0:    page_base = RAM_ADDR_W'(ROM_BASE) + (RAM_ADDR_W'(rom_sel) << PAGE_OFS_W);
			2'd1:    page_base = RAM_ADDR_W'(PAGE_SCREEN_LO) << PAGE_OFS_W;
			2'd2:    page_base = RAM_ADDR_W'(PAGE_MID) << PAGE_OFS_W;
			default: page_base = RAM_ADDR_W'(page_ram) << PAGE_OFS_W;
		endcase
	end

	assign cpu_maddr  = page_base | RAM_ADDR_W'(cpu_addr[PAGE_OFS_W-1:0]);
	assign cpu_mwdata = cpu_wdata;

	// ROM writes go out as reads so the cycle still completes
	assign cpu_we = wr & ~rom_window;

	// Request drops as soon as the data comes back
	assign cpu_req   = access & (state != st_done) & ~cpu_rvalid;
	assign cpu_ready = (state == st_done) & mreq;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (access) state <= st_wait;
				st_wait: if (cpu_rvalid) state <= st_done;
				st_done: if (!mreq) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (cpu_rvalid) begin
			cpu_din <= mem_rdata;
		end
	end

endmodule

// File: verilog/io_ports.sv
// I/O write decode for the 128K paging register and the border port
// Holds the lock bit and the machine mode latched at reset

module io_ports (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 machine_sel,
	input  logic [15:0]          cpu_addr,
	input  logic [7:0]           cpu_wdata,
	input  logic                 iorq,
	input  logic                 wr,
	output logic [2:0]           page_ram,
	output logic                 rom_sel,
	output zx_bus_pkg::machine_t machine,
	output logic [2:0]           border_color,
	output logic                 ear_out,
	output logic                 mic_out
);
	import zx_mem_pkg::*;
	import zx_bus_pkg::*;

	logic io_wr;
	logic io_wr_q;
	logic io_wr_rise;
	logic page_write;
	logic ula_write;
	logic rom_bit;
	logic lock_bit;

	// Act once per I/O write, on its first cycle
	assign io_wr      = iorq & wr;
	assign io_wr_rise = io_wr & ~io_wr_q;

	assign page_write = ~cpu_addr[PORT7FFD_A15_BIT] & ~cpu_addr[PORT7FFD_A1_BIT] &
		(machine == machine_128) & ~lock_bit;
	assign ula_write  = ~cpu_addr[ULA_A0_BIT];

	// 48K machines only ever see ROM 1
	assign rom_sel = rom_bit | (machine == machine_48);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
		end
	end

	// ==================================================
	// Paging register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			machine  <= machine_t'(machine_sel);
			page_ram <= '0;
			rom_bit  <= 1'b0;
			lock_bit <= 1'b0;
		end else if (io_wr_rise && page_write) begin
			page_ram <= cpu_wdata[PG_RAM_MSB:PG_RAM_LSB];
			rom_bit  <= cpu_wdata[PG_ROM_BIT];
			lock_bit <= cpu_wdata[PG_LOCK_BIT];
		end
	end

	// ==================================================
	// Border, mic and ear
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr_rise && ula_write) begin
			border_color <= cpu_wdata[ULA_BORDER_MSB:0];
			mic_out      <= cpu_wdata[ULA_MIC_BIT];
			ear_out      <= cpu_wdata[ULA_EAR_BIT];
		end
	end

endmodule

// File: verilog/mem_arbiter.sv
// Fixed-priority arbiter for the shared memory port
// Loader first, then tape, then CPU, with the read-valid return path

module mem_arbiter (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              load_active,
	input  logic                              load_wr,
	input  logic [zx_mem_pkg::RAM_ADDR_W-1:0] load_addr,
	input  logic [7:0]                        load_data,
	input  logic                              cpu_req,
	input  logic                              cpu_we,
	input  logic [zx_mem_pkg::RAM_ADDR_W-1:0] cpu_maddr,
	input  logic [7:0]                        cpu_mwdata,
	input  logic                              tape_req,
	input  logic [zx_mem_pkg::RAM_ADDR_W-1:0] tape_maddr,
	output logic                              cpu_gnt,
	output logic                              tape_gnt,
	output logic                              cpu_rvalid,
	output logic                              tape_rvalid,
	output logic                              mem_en,
	output logic                              mem_we,
	output logic [zx_mem_pkg::RAM_ADDR_W-1:0] mem_addr,
	output logic [7:0]                        mem_wdata
);
	import zx_bus_pkg::*;

	mem_grant_t gnt;
	mem_grant_t gnt_q;

	// ==================================================
	// Grant select
	// An active loader owns the memory even between its strobes
	always_comb begin
		if (load_active) begin
			gnt = load_wr ? grant_loader : grant_none;
		end else if (tape_req) begin
			gnt = grant_tape;
		end else if (cpu_req) begin
			gnt = grant_cpu;
		end else begin
			gnt = grant_none;
		end
	end

	assign cpu_gnt  = (gnt == grant_cpu);
	assign tape_gnt = (gnt == grant_tape);
	assign mem_en   = (gnt != grant_none);

	// Memory port mux
	always_comb begin
		mem_we    = 1'b0;
		mem_addr  = cpu_maddr;
		mem_wdata = cpu_mwdata;
		case (gnt)
			grant_loader: begin
				mem_we    = 1'b1;
				mem_addr  = load_addr;
				mem_wdata = load_data;
			end
			grant_tape: mem_addr = tape_maddr;
			grant_cpu:  mem_we = cpu_we;
			default:    mem_we = 1'b0;
		endcase
	end

	// ==================================================
	// Return path, data is back one cycle after the grant
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gnt_q <= grant_none;
		end else begin
			gnt_q <= gnt;
		end
	end

	// Loader writes need no completion
	assign cpu_rvalid  = (gnt_q == grant_cpu);
	assign tape_rvalid = (gnt_q == grant_tape);

endmodule

// File: verilog/ram_store.sv
// Single-port byte memory with a registered read
// Read during write returns the old byte

module ram_store (
	input  logic                              clk_sys,
	input  logic                              mem_en,
	input  logic                              mem_we,
	input  logic [zx_mem_pkg::RAM_ADDR_W-1:0] mem_addr,
	input  logic [7:0]                        mem_wdata,
	output logic [7:0]                        mem_rdata
);
	import zx_mem_pkg::*;

	logic [7:0] mem [0:(1 << RAM_ADDR_W) - 1];

	always_ff @(posedge clk_sys) begin
		if (mem_en) begin
			if (mem_we) begin
				mem[mem_addr] <= mem_wdata;
			end
			mem_rdata <= mem[mem_addr];
		end
	end

endmodule

// File: verilog/tape_reader.sv
// Sequential byte fetcher for the tape buffer
// One fetch at a time from TAPE_BASE plus a running pointer

module tape_reader #(
	parameter int TAPE_PTR_W = 16
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              tape_next,
	input  logic                              tape_rewind,
	input  logic                              tape_rvalid,
	input  logic [7:0]                        mem_rdata,
	output logic                              tape_req,
	output logic [zx_mem_pkg::RAM_ADDR_W-1:0] tape_maddr,
	output logic [7:0]                        tape_byte,
	output logic                              tape_byte_valid
);
	import zx_mem_pkg::*;

	logic [TAPE_PTR_W-1:0] ptr;
	logic                  pending;

	assign tape_req   = pending & ~tape_rvalid;
	assign tape_maddr = RAM_ADDR_W'(TAPE_BASE) + RAM_ADDR_W'(ptr);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ptr             <= '0;
			pending         <= 1'b0;
			tape_byte_valid <= 1'b0;
		end else begin
			tape_byte_valid <= tape_rvalid;
			if (tape_rvalid) begin
				pending <= 1'b0;
			end else if (tape_next) begin
				pending <= 1'b1;
			end
			// Rewind takes priority over the advance
			if (tape_rewind) begin
				ptr <= '0;
			end else if (tape_rvalid) begin
				ptr <= ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tape_rvalid) tape_byte <= mem_rdata;
	end

endmodule

// File: verilog/zx_bus_pkg.sv
// Bus-side definitions
// Memory grant and machine mode enums, I/O decode and border port bits

package zx_bus_pkg;

	// Owner of the shared memory in one cycle
	typedef enum logic [1:0] {
		grant_none   = 2'd0,
		grant_loader = 2'd1,
		grant_tape   = 2'd2,
		grant_cpu    = 2'd3
	} mem_grant_t;

	// Machine type latched at reset
	typedef enum logic {
		machine_128 = 1'b0,
		machine_48  = 1'b1
	} machine_t;

	// Port 7FFD decodes on A15 and A1 low
	localparam int PORT7FFD_A15_BIT = 15;
	localparam int PORT7FFD_A1_BIT  = 1;

	// Border port answers on every even address
	localparam int ULA_A0_BIT     = 0;
	localparam int ULA_BORDER_MSB = 2;
	localparam int ULA_MIC_BIT    = 3;
	localparam int ULA_EAR_BIT    = 4;

endpackage

// File: verilog/zx_mem_pkg.sv
// Memory map of the shared byte memory
// Address widths, fixed pages, region bases and paging register fields

package zx_mem_pkg;

	// Physical layout of the 256K byte memory
	//   00000-1FFFF  RAM pages 0 to 7
	//   20000-27FFF  ROM 0 and ROM 1
	//   30000-3FFFF  tape buffer

	// Width of a physical byte address
	localparam int RAM_ADDR_W = 18;

	// Offset bits inside one 16K page
	localparam int PAGE_OFS_W = 14;

	// Pages wired to 4000 and 8000
	localparam int PAGE_SCREEN_LO = 5;
	localparam int PAGE_MID       = 2;

	// Start of the two ROM pages
	localparam int ROM_BASE = 32'h0002_0000;

	// Start of the tape region
	localparam int TAPE_BASE = 32'h0003_0000;

	// Port 7FFD fields
	localparam int PG_RAM_LSB  = 0;
	localparam int PG_RAM_MSB  = 2;
	localparam int PG_ROM_BIT  = 4;

	// Once set, paging stays frozen until reset
	localparam int PG_LOCK_BIT = 5;

endpackage

// File: verilog/zx_mem_top.sv
// Top level of the 128K memory subsystem
// I/O ports, CPU client, tape reader, arbiter and shared memory

module zx_mem_top #(
	parameter int TAPE_PTR_W = 16
) (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              machine_sel,
	input  logic [15:0]                       cpu_addr,
	input  logic [7:0]                        cpu_wdata,
	input  logic                              mreq,
	input  logic                              iorq,
	input  logic                              rd,
	input  logic                              wr,
	input  logic                              load_active,
	input  logic                              load_wr,
	input  logic [zx_mem_pkg::RAM_ADDR_W-1:0] load_addr,
	input  logic [7:0]                        load_data,
	input  logic                              tape_next,
	input  logic                              tape_rewind,
	output logic [7:0]                        cpu_din,
	output logic                              cpu_ready,
	output logic [2:0]                        border_color,
	output logic                              ear_out,
	output logic                              mic_out,
	output logic [7:0]                        tape_byte,
	output logic                              tape_byte_valid
);
	import zx_mem_pkg::*;

	// Paging state
	logic [2:0] page_ram;
	logic       rom_sel;

	// Client requests and returns
	logic                  cpu_req;
	logic                  cpu_we;
	logic [RAM_ADDR_W-1:0] cpu_maddr;
	logic [7:0]            cpu_mwdata;
	logic                  cpu_rvalid;
	logic                  tape_req;
	logic [RAM_ADDR_W-1:0] tape_maddr;
	logic                  tape_rvalid;

	// Memory port
	logic                  mem_en;
	logic                  mem_we;
	logic [RAM_ADDR_W-1:0] mem_addr;
	logic [7:0]            mem_wdata;
	logic [7:0]            mem_rdata;

	// ==================================================
	io_ports ports_i (
		.clk_sys(clk_sys), .reset(reset), .machine_sel(machine_sel),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .iorq(iorq), .wr(wr),
		.page_ram(page_ram), .rom_sel(rom_sel), .machine(),
		.border_color(border_color), .ear_out(ear_out), .mic_out(mic_out)
	);

	cpu_mem_client cpu_i (
		.clk_sys(clk_sys), .reset(reset), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.mreq(mreq), .rd(rd), .wr(wr), .page_ram(page_ram), .rom_sel(rom_sel),
		.cpu_rvalid(cpu_rvalid), .mem_rdata(mem_rdata), .cpu_req(cpu_req),
		.cpu_we(cpu_we), .cpu_maddr(cpu_maddr), .cpu_mwdata(cpu_mwdata),
		.cpu_din(cpu_din), .cpu_ready(cpu_ready)
	);

	tape_reader #(.TAPE_PTR_W(TAPE_PTR_W)) tape_i (
		.clk_sys(clk_sys), .reset(reset), .tape_next(tape_next),
		.tape_rewind(tape_rewind), .tape_rvalid(tape_rvalid), .mem_rdata(mem_rdata),
		.tape_req(tape_req), .tape_maddr(tape_maddr), .tape_byte(tape_byte),
		.tape_byte_valid(tape_byte_valid)
	);

	// Grant strobes are observed inside the arbiter only
	mem_arbiter arb_i (
		.clk_sys(clk_sys), .reset(reset), .load_active(load_active), .load_wr(load_wr),
		.load_addr(load_addr), .load_data(load_data), .cpu_req(cpu_req), .cpu_we(cpu_we),
		.cpu_maddr(cpu_maddr), .cpu_mwdata(cpu_mwdata), .tape_req(tape_req),
		.tape_maddr(tape_maddr), .cpu_gnt(), .tape_gnt(), .cpu_rvalid(cpu_rvalid),
		.tape_rvalid(tape_rvalid), .mem_en(mem_en), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	ram_store ram_i (
		.clk_sys(clk_sys), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
	);

endmodule

// File: vlog.f
verilog/zx_mem_pkg.sv
verilog/zx_bus_pkg.sv
verilog/io_ports.sv
verilog/cpu_mem_client.sv
verilog/tape_reader.sv
verilog/mem_arbiter.sv
verilog/ram_store.sv
verilog/zx_mem_top.sv
dv/zx_mem_assert.sv
dv/zx_mem_tb.sv
